// ==== tlb_pkg.sv ====
`default_nettype none

package tlb_pkg;

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [18:0] vpn2_t;    // vaddr[31:13]
    typedef logic [7:0]  asid_t;
    typedef logic [19:0] pfn_t;
    typedef logic [2:0]  cattr_t;
    typedef logic [3:0]  tlb_index_t;

    // one page {pfn, c, d, v}, lines up with entrylo[25:1]
    typedef logic [24:0] page_t;

    localparam int page_pfn_lsb = 5;
    localparam int page_c_lsb   = 2;
    localparam int page_d_bit   = 1;
    localparam int page_v_bit   = 0;

    typedef logic [7:0]  axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [1:0]  axil_resp_t;

    localparam axil_resp_t resp_okay   = 2'b00;
    localparam axil_resp_t resp_slverr = 2'b10;

    localparam axil_addr_t reg_index    = 8'h00;   // [31] probe fail, [3:0] index
    localparam axil_addr_t reg_random   = 8'h04;   // read only
    localparam axil_addr_t reg_entrylo0 = 8'h08;   // pfn[25:6] c[5:3] d v g
    localparam axil_addr_t reg_entrylo1 = 8'h0C;
    localparam axil_addr_t reg_entryhi  = 8'h10;   // vpn2[31:13] asid[7:0]
    localparam axil_addr_t reg_command  = 8'h14;   // write only

    typedef logic [2:0] tlb_cmd_t;

    localparam tlb_cmd_t cmd_tlbwi = 3'd1;
    localparam tlb_cmd_t cmd_tlbwr = 3'd2;
    localparam tlb_cmd_t cmd_tlbp  = 3'd3;
    localparam tlb_cmd_t cmd_tlbr  = 3'd4;

    typedef enum logic {
        wr_idle,
        wr_resp
    } wr_state_t;

    typedef enum logic {
        rd_idle,
        rd_resp
    } rd_state_t;

endpackage

`default_nettype wire

// ==== tlb_entries.sv ====
`default_nettype none
`timescale 1ns/10ps

module tlb_entries #(
    parameter int TLB_ENTRIES = 16
) (
    input  wire                 aclk,
    input  wire                 rst_n,
    input  wire                 we,
    input  tlb_pkg::tlb_index_t windex,
    input  tlb_pkg::vpn2_t      wvpn2,
    input  tlb_pkg::asid_t      wasid,
    input  wire                 wg,
    input  tlb_pkg::page_t      wpage0,
    input  tlb_pkg::page_t      wpage1,
    input  tlb_pkg::tlb_index_t rindex,
    output tlb_pkg::vpn2_t      rvpn2,
    output tlb_pkg::asid_t      rasid,
    output logic                rg,
    output tlb_pkg::page_t      rpage0,
    output tlb_pkg::page_t      rpage1,
    output tlb_pkg::vpn2_t      arr_vpn2  [TLB_ENTRIES],
    output tlb_pkg::asid_t      arr_asid  [TLB_ENTRIES],
    output logic                arr_g     [TLB_ENTRIES],
    output tlb_pkg::page_t      arr_page0 [TLB_ENTRIES],
    output tlb_pkg::page_t      arr_page1 [TLB_ENTRIES]
);

    logic wr_ok;
    logic rd_ok;

    // index register is wider than a small TLB
    assign wr_ok = we && (int'(windex) < TLB_ENTRIES);
    assign rd_ok = int'(rindex) < TLB_ENTRIES;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                arr_vpn2[i]  <= '0;
                arr_asid[i]  <= '0;
                arr_g[i]     <= 1'b0;
                arr_page0[i] <= '0;
                arr_page1[i] <= '0;
            end
        end else if (wr_ok) begin
            arr_vpn2[windex]  <= wvpn2;
            arr_asid[windex]  <= wasid;
            arr_g[windex]     <= wg;
            arr_page0[windex] <= wpage0;
            arr_page1[windex] <= wpage1;
        end
    end

    // combinational read for tlbr
    assign rvpn2  = rd_ok ? arr_vpn2[rindex] : '0;
    assign rasid  = rd_ok ? arr_asid[rindex] : '0;
    assign rg     = rd_ok ? arr_g[rindex] : 1'b0;
    assign rpage0 = rd_ok ? arr_page0[rindex] : '0;
    assign rpage1 = rd_ok ? arr_page1[rindex] : '0;

endmodule

`default_nettype wire

// ==== tlb_lookup.sv ====
`default_nettype none
`timescale 1ns/10ps

module tlb_lookup #(
    parameter int TLB_ENTRIES = 16
) (
    input  wire                 aclk,
    input  wire                 rst_n,
    input  tlb_pkg::vpn2_t      arr_vpn2  [TLB_ENTRIES],
    input  tlb_pkg::asid_t      arr_asid  [TLB_ENTRIES],
    input  wire                 arr_g     [TLB_ENTRIES],
    input  tlb_pkg::page_t      arr_page0 [TLB_ENTRIES],
    input  tlb_pkg::page_t      arr_page1 [TLB_ENTRIES],
    input  tlb_pkg::asid_t      cur_asid,
    input  wire                 req_valid,
    input  tlb_pkg::vaddr_t     req_vaddr,
    output logic                match_hit,
    output tlb_pkg::tlb_index_t match_index,
    output logic                rsp_valid,
    output logic                rsp_hit,
    output tlb_pkg::paddr_t     rsp_paddr,
    output tlb_pkg::cattr_t     rsp_c,
    output logic                rsp_d,
    output logic                rsp_v
);

    tlb_pkg::vpn2_t req_vpn2;
    tlb_pkg::page_t sel_page;
    tlb_pkg::page_t hit_page;
    tlb_pkg::pfn_t  hit_pfn;

    assign req_vpn2 = req_vaddr[31:13];

    // walk down so the lowest matching entry is the one left standing
    always_comb begin
        match_hit   = 1'b0;
        match_index = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (arr_vpn2[i] == req_vpn2 && (arr_g[i] || arr_asid[i] == cur_asid)) begin
                match_hit   = 1'b1;
                match_index = tlb_pkg::tlb_index_t'(i);
            end
        end
    end

    assign sel_page = req_vaddr[12] ? arr_page1[match_index] : arr_page0[match_index];
    assign hit_page = match_hit ? sel_page : '0;   // miss reads as all zero
    assign hit_pfn  = hit_page[tlb_pkg::page_pfn_lsb +: $bits(tlb_pkg::pfn_t)];

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
            rsp_hit   <= 1'b0;
        end else begin
            rsp_valid <= req_valid;
            if (req_valid) rsp_hit <= match_hit;
        end
    end

    always_ff @(posedge aclk) begin
        if (req_valid) begin
            rsp_paddr <= match_hit ? {hit_pfn, req_vaddr[11:0]} : '0;
            rsp_c     <= hit_page[tlb_pkg::page_c_lsb +: $bits(tlb_pkg::cattr_t)];
            rsp_d     <= hit_page[tlb_pkg::page_d_bit];
            rsp_v     <= hit_page[tlb_pkg::page_v_bit];
        end
    end

endmodule

`default_nettype wire

// ==== tlb_regs.sv ====
`default_nettype none
`timescale 1ns/10ps

module tlb_regs #(
    parameter int TLB_ENTRIES = 16
) (
    input  wire                 aclk,
    input  wire                 rst_n,
    input  tlb_pkg::axil_addr_t awaddr,
    input  wire                 awvalid,
    output logic                awready,
    input  tlb_pkg::axil_data_t wdata,
    input  wire  [3:0]          wstrb,      // full-word writes only
    input  wire                 wvalid,
    output logic                wready,
    output tlb_pkg::axil_resp_t bresp,
    output logic                bvalid,
    input  wire                 bready,
    input  tlb_pkg::axil_addr_t araddr,
    input  wire                 arvalid,
    output logic                arready,
    output tlb_pkg::axil_data_t rdata,
    output tlb_pkg::axil_resp_t rresp,
    output logic                rvalid,
    input  wire                 rready,
    output logic                ent_we,
    output tlb_pkg::tlb_index_t ent_windex,
    output tlb_pkg::vpn2_t      ent_wvpn2,
    output tlb_pkg::asid_t      ent_wasid,
    output logic                ent_wg,
    output tlb_pkg::page_t      ent_wpage0,
    output tlb_pkg::page_t      ent_wpage1,
    output tlb_pkg::tlb_index_t ent_rindex,
    input  tlb_pkg::vpn2_t      ent_rvpn2,
    input  tlb_pkg::asid_t      ent_rasid,
    input  wire                 ent_rg,
    input  tlb_pkg::page_t      ent_rpage0,
    input  tlb_pkg::page_t      ent_rpage1,
    output tlb_pkg::asid_t      cur_asid,
    output tlb_pkg::vpn2_t      probe_vpn2,
    input  wire                 probe_hit,
    input  tlb_pkg::tlb_index_t probe_index
);

    tlb_pkg::wr_state_t  wr_state;
    tlb_pkg::rd_state_t  rd_state;
    logic                wr_accept;
    logic                wr_known;
    logic                do_cmd;
    tlb_pkg::tlb_cmd_t   cmd;
    logic                rd_accept;
    logic                rd_known;
    tlb_pkg::axil_data_t rd_word;

    logic                idx_p;
    tlb_pkg::tlb_index_t idx_val;
    tlb_pkg::tlb_index_t rnd;
    tlb_pkg::page_t      lo0_page;
    tlb_pkg::page_t      lo1_page;
    logic                lo0_g;
    logic                lo1_g;
    tlb_pkg::vpn2_t      hi_vpn2;
    tlb_pkg::asid_t      hi_asid;

    assign awready   = (wr_state == tlb_pkg::wr_idle);
    assign wready    = (wr_state == tlb_pkg::wr_idle);
    assign bvalid    = (wr_state == tlb_pkg::wr_resp);
    assign wr_accept = awready && awvalid && wvalid;   // aw and w together
    assign cmd       = wdata[2:0];
    assign do_cmd    = wr_accept && (awaddr == tlb_pkg::reg_command);

    always_comb begin
        case (awaddr)
            tlb_pkg::reg_index, tlb_pkg::reg_entrylo0, tlb_pkg::reg_entrylo1,
            tlb_pkg::reg_entryhi, tlb_pkg::reg_command: wr_known = 1'b1;
            default: wr_known = 1'b0;
        endcase
    end

    // entry write port, data straight from the cp0 registers
    assign ent_we     = do_cmd && (cmd == tlb_pkg::cmd_tlbwi || cmd == tlb_pkg::cmd_tlbwr);
    assign ent_windex = (cmd == tlb_pkg::cmd_tlbwr) ? rnd : idx_val;
    assign ent_wvpn2  = hi_vpn2;
    assign ent_wasid  = hi_asid;
    assign ent_wg     = lo0_g & lo1_g;
    assign ent_wpage0 = lo0_page;
    assign ent_wpage1 = lo1_page;
    assign ent_rindex = idx_val;    // tlbr source

    assign cur_asid   = hi_asid;
    assign probe_vpn2 = hi_vpn2;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_state <= tlb_pkg::wr_idle;
        end else begin
            case (wr_state)
                tlb_pkg::wr_idle: if (wr_accept) wr_state <= tlb_pkg::wr_resp;
                tlb_pkg::wr_resp: if (bready) wr_state <= tlb_pkg::wr_idle;
                default: wr_state <= tlb_pkg::wr_idle;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_accept) begin
            bresp <= wr_known ? tlb_pkg::resp_okay : tlb_pkg::resp_slverr;
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            idx_p    <= 1'b0;
            idx_val  <= '0;
            rnd      <= tlb_pkg::tlb_index_t'(TLB_ENTRIES - 1);
            lo0_page <= '0;
            lo0_g    <= 1'b0;
            lo1_page <= '0;
            lo1_g    <= 1'b0;
            hi_vpn2  <= '0;
            hi_asid  <= '0;
        end else if (wr_accept) begin
            case (awaddr)
                tlb_pkg::reg_index: idx_val <= wdata[3:0];  // flag belongs to tlbp
                tlb_pkg::reg_entrylo0: begin
                    lo0_page <= wdata[25:1];
                    lo0_g    <= wdata[0];
                end
                tlb_pkg::reg_entrylo1: begin
                    lo1_page <= wdata[25:1];
                    lo1_g    <= wdata[0];
                end
                tlb_pkg::reg_entryhi: begin
                    hi_vpn2 <= wdata[31:13];
                    hi_asid <= wdata[7:0];
                end
                tlb_pkg::reg_command: begin
                    case (cmd)
                        tlb_pkg::cmd_tlbwr: begin
                            // counts down, wraps to top entry
                            if (rnd == '0) begin
                                rnd <= tlb_pkg::tlb_index_t'(TLB_ENTRIES - 1);
                            end else begin
                                rnd <= rnd - 1'b1;
                            end
                        end
                        tlb_pkg::cmd_tlbp: begin
                            idx_p   <= ~probe_hit;
                            idx_val <= probe_hit ? probe_index : '0;
                        end
                        tlb_pkg::cmd_tlbr: begin
                            hi_vpn2  <= ent_rvpn2;
                            hi_asid  <= ent_rasid;
                            lo0_page <= ent_rpage0;
                            lo1_page <= ent_rpage1;
                            lo0_g    <= ent_rg;
                            lo1_g    <= ent_rg;
                        end
                        default: ;  // tlbwi handled by entry port
                    endcase
                end
                default: ;
            endcase
        end
    end

    assign arready   = (rd_state == tlb_pkg::rd_idle);
    assign rvalid    = (rd_state == tlb_pkg::rd_resp);
    assign rd_accept = arready && arvalid;

    always_comb begin
        rd_known = 1'b1;
        case (araddr)
            tlb_pkg::reg_index:    rd_word = {idx_p, 27'd0, idx_val};
            tlb_pkg::reg_random:   rd_word = {28'd0, rnd};
            tlb_pkg::reg_entrylo0: rd_word = {6'd0, lo0_page, lo0_g};
            tlb_pkg::reg_entrylo1: rd_word = {6'd0, lo1_page, lo1_g};
            tlb_pkg::reg_entryhi:  rd_word = {hi_vpn2, 5'd0, hi_asid};
            default: begin
                rd_known = 1'b0;
                rd_word  = '0;
            end
        endcase
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            rd_state <= tlb_pkg::rd_idle;
        end else begin
            case (rd_state)
                tlb_pkg::rd_idle: if (rd_accept) rd_state <= tlb_pkg::rd_resp;
                tlb_pkg::rd_resp: if (rready) rd_state <= tlb_pkg::rd_idle;
                default: rd_state <= tlb_pkg::rd_idle;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (rd_accept) begin
            rdata <= rd_word;
            rresp <= rd_known ? tlb_pkg::resp_okay : tlb_pkg::resp_slverr;
        end
    end

endmodule

`default_nettype wire

// ==== tlb_mmu_top.sv ====
`default_nettype none
`timescale 1ns/10ps

module tlb_mmu_top #(
    parameter int TLB_ENTRIES = 16
) (
    input  wire                 aclk,
    input  wire                 rst_n,
    input  tlb_pkg::axil_addr_t awaddr,
    input  wire                 awvalid,
    output logic                awready,
    input  tlb_pkg::axil_data_t wdata,
    input  wire  [3:0]          wstrb,
    input  wire                 wvalid,
    output logic                wready,
    output tlb_pkg::axil_resp_t bresp,
    output logic                bvalid,
    input  wire                 bready,
    input  tlb_pkg::axil_addr_t araddr,
    input  wire                 arvalid,
    output logic                arready,
    output tlb_pkg::axil_data_t rdata,
    output tlb_pkg::axil_resp_t rresp,
    output logic                rvalid,
    input  wire                 rready,
    input  wire                 if_req_valid,
    input  tlb_pkg::vaddr_t     if_vaddr,
    output logic                if_rsp_valid,
    output logic                if_hit,
    output tlb_pkg::paddr_t     if_paddr,
    output tlb_pkg::cattr_t     if_c,
    output logic                if_d,
    output logic                if_v,
    input  wire                 dm_req_valid,
    input  tlb_pkg::vaddr_t     dm_vaddr,
    output logic                dm_rsp_valid,
    output logic                dm_hit,
    output tlb_pkg::paddr_t     dm_paddr,
    output tlb_pkg::cattr_t     dm_c,
    output logic                dm_d,
    output logic                dm_v
);

    logic                ent_we;
    tlb_pkg::tlb_index_t ent_windex;
    tlb_pkg::vpn2_t      ent_wvpn2;
    tlb_pkg::asid_t      ent_wasid;
    logic                ent_wg;
    tlb_pkg::page_t      ent_wpage0;
    tlb_pkg::page_t      ent_wpage1;
    tlb_pkg::tlb_index_t ent_rindex;
    tlb_pkg::vpn2_t      ent_rvpn2;
    tlb_pkg::asid_t      ent_rasid;
    logic                ent_rg;
    tlb_pkg::page_t      ent_rpage0;
    tlb_pkg::page_t      ent_rpage1;
    tlb_pkg::asid_t      cur_asid;
    tlb_pkg::vpn2_t      probe_vpn2;
    logic                probe_hit;
    tlb_pkg::tlb_index_t probe_index;

    tlb_pkg::vpn2_t      arr_vpn2  [TLB_ENTRIES];
    tlb_pkg::asid_t      arr_asid  [TLB_ENTRIES];
    logic                arr_g     [TLB_ENTRIES];
    tlb_pkg::page_t      arr_page0 [TLB_ENTRIES];
    tlb_pkg::page_t      arr_page1 [TLB_ENTRIES];

    tlb_regs #(.TLB_ENTRIES(TLB_ENTRIES)) u_regs (.*);

    tlb_entries #(.TLB_ENTRIES(TLB_ENTRIES)) u_entries (
        .aclk   (aclk),       .rst_n  (rst_n),
        .we     (ent_we),     .windex (ent_windex),
        .wvpn2  (ent_wvpn2),  .wasid  (ent_wasid),   .wg     (ent_wg),
        .wpage0 (ent_wpage0), .wpage1 (ent_wpage1),  .rindex (ent_rindex),
        .rvpn2  (ent_rvpn2),  .rasid  (ent_rasid),   .rg     (ent_rg),
        .rpage0 (ent_rpage0), .rpage1 (ent_rpage1),
        .arr_vpn2, .arr_asid, .arr_g, .arr_page0, .arr_page1
    );

    tlb_lookup #(.TLB_ENTRIES(TLB_ENTRIES)) u_if_lookup (
        .*,
        .req_valid (if_req_valid), .req_vaddr (if_vaddr),
        .match_hit (),             .match_index (),
        .rsp_valid (if_rsp_valid), .rsp_hit   (if_hit),  .rsp_paddr (if_paddr),
        .rsp_c     (if_c),         .rsp_d     (if_d),    .rsp_v     (if_v)
    );

    tlb_lookup #(.TLB_ENTRIES(TLB_ENTRIES)) u_dm_lookup (
        .*,
        .req_valid (dm_req_valid), .req_vaddr (dm_vaddr),
        .match_hit (),             .match_index (),
        .rsp_valid (dm_rsp_valid), .rsp_hit   (dm_hit),  .rsp_paddr (dm_paddr),
        .rsp_c     (dm_c),         .rsp_d     (dm_d),    .rsp_v     (dm_v)
    );

    // tlbp only needs the combinational match on entryhi
    tlb_lookup #(.TLB_ENTRIES(TLB_ENTRIES)) u_probe_lookup (
        .*,
        .req_valid (1'b0),         .req_vaddr ({probe_vpn2, 13'd0}),
        .match_hit (probe_hit),    .match_index (probe_index),
        .rsp_valid (),             .rsp_hit   (),        .rsp_paddr (),
        .rsp_c     (),             .rsp_d     (),        .rsp_v     ()
    );

endmodule

`default_nettype wire

// ==== tb_tlb_mmu.sv ====
`default_nettype none
`timescale 1ns/10ps

module tb_tlb_mmu;

    localparam int clk_period = 40;
    localparam int in_delay   = 2;
    localparam tlb_pkg::axil_resp_t ok  = tlb_pkg::resp_okay;
    localparam tlb_pkg::axil_resp_t err = tlb_pkg::resp_slverr;

    typedef enum {op_wr, op_rd, op_if, op_dm} op_t;

    typedef struct {
        op_t                 op;
        tlb_pkg::axil_addr_t addr;
        logic [31:0]         data;    // write data, expected read data, or vaddr
        int                  stall;   // b/r stall cycles, or lookups in a burst
        tlb_pkg::axil_resp_t resp;
    } row_t;

    logic aclk = 1'b0;
    logic rst_n;
    tlb_pkg::axil_addr_t awaddr;
    logic                awvalid;
    logic                awready;
    tlb_pkg::axil_data_t wdata;
    logic [3:0]          wstrb;
    logic                wvalid;
    logic                wready;
    tlb_pkg::axil_resp_t bresp;
    logic                bvalid;
    logic                bready;
    tlb_pkg::axil_addr_t araddr;
    logic                arvalid;
    logic                arready;
    tlb_pkg::axil_data_t rdata;
    tlb_pkg::axil_resp_t rresp;
    logic                rvalid;
    logic                rready;
    logic                if_req_valid;
    tlb_pkg::vaddr_t     if_vaddr;
    logic                if_rsp_valid;
    logic                if_hit;
    tlb_pkg::paddr_t     if_paddr;
    tlb_pkg::cattr_t     if_c;
    logic                if_d;
    logic                if_v;
    logic                dm_req_valid;
    tlb_pkg::vaddr_t     dm_vaddr;
    logic                dm_rsp_valid;
    logic                dm_hit;
    tlb_pkg::paddr_t     dm_paddr;
    tlb_pkg::cattr_t     dm_c;
    logic                dm_d;
    logic                dm_v;

    row_t        rows[$];
    int          n_rows = 0;
    int          n_pass = 0;
    int          n_fail = 0;
    int          cur_row;
    logic        row_bad;
    logic [31:0] rnd_state = 32'h450e;

    // reference model of the cp0 registers and the entry array
    logic [31:0] m_hi, m_lo0, m_lo1;
    logic [3:0]  m_index, m_random;
    logic [31:0] m_ent_hi  [16];    // vpn2 and asid as in entryhi
    logic [31:0] m_ent_lo0 [16];    // entrylo layout, g cleared
    logic [31:0] m_ent_lo1 [16];
    logic        m_ent_g   [16];

    tlb_mmu_top #(.TLB_ENTRIES(16)) uut (.*);

    always #(clk_period / 2) aclk = ~aclk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // entrylo word with a fresh random pfn
    function automatic logic [31:0] make_lo(input logic [2:0] c, input logic d, v, g);
        rnd_state = xorshift(rnd_state);
        return {6'd0, rnd_state[19:0], c, d, v, g};
    endfunction

    function automatic int find_entry(input logic [18:0] vpn2, input logic [7:0] asid);
        for (int i = 0; i < 16; i++) begin
            if (m_ent_hi[i][31:13] == vpn2 && (m_ent_g[i] || m_ent_hi[i][7:0] == asid)) begin
                return i;   // lowest index wins
            end
        end
        return -1;
    endfunction

    task automatic store_entry(input logic [3:0] i);
        m_ent_hi[i]  = m_hi;
        m_ent_lo0[i] = m_lo0 & ~32'd1;
        m_ent_lo1[i] = m_lo1 & ~32'd1;
        m_ent_g[i]   = m_lo0[0] & m_lo1[0];
    endtask

    task automatic model_write(input tlb_pkg::axil_addr_t a, input logic [31:0] d);
        int e;
        case (a)
            tlb_pkg::reg_index:    m_index = d[3:0];
            tlb_pkg::reg_entrylo0: m_lo0 = d & 32'h03ff_ffff;
            tlb_pkg::reg_entrylo1: m_lo1 = d & 32'h03ff_ffff;
            tlb_pkg::reg_entryhi:  m_hi = d & 32'hffff_e0ff;
            tlb_pkg::reg_command: begin
                case (d[2:0])
                    tlb_pkg::cmd_tlbwi: store_entry(m_index);
                    tlb_pkg::cmd_tlbwr: begin
                        store_entry(m_random);
                        m_random = (m_random == 4'd0) ? 4'd15 : m_random - 4'd1;
                    end
                    tlb_pkg::cmd_tlbp: begin
                        e = find_entry(m_hi[31:13], m_hi[7:0]);
                        m_index = (e < 0) ? 4'd0 : 4'(e);
                    end
                    tlb_pkg::cmd_tlbr: begin
                        m_hi  = m_ent_hi[m_index];
                        m_lo0 = m_ent_lo0[m_index] | 32'(m_ent_g[m_index]);
                        m_lo1 = m_ent_lo1[m_index] | 32'(m_ent_g[m_index]);
                    end
                    default: ;
                endcase
            end
            default: ;  // read-only or unknown offset
        endcase
    endtask

    task automatic note_mismatch(input string msg);
        $display("mismatch at %0d ns: row %0d %s", $time, cur_row, msg);
        row_bad = 1'b1;
    endtask

    task automatic add_row(input op_t op, input tlb_pkg::axil_addr_t a, input logic [31:0] d,
                           input int stall, input tlb_pkg::axil_resp_t resp);
        row_t r;
        r = '{op, a, d, stall, resp};
        rows.push_back(r);
    endtask

    task automatic wr_step(input tlb_pkg::axil_addr_t a, input logic [31:0] d);
        add_row(op_wr, a, d, 0, ok);
    endtask

    task automatic rd_step(input tlb_pkg::axil_addr_t a, input logic [31:0] expected);
        add_row(op_rd, a, expected, 0, ok);
    endtask

    task automatic build_table();
        logic [31:0] a_lo0, a_lo1, b_lo0, b_lo1;
        // reset state
        rd_step(tlb_pkg::reg_index, 32'd0);
        rd_step(tlb_pkg::reg_random, 32'd15);
        rd_step(tlb_pkg::reg_entrylo0, 32'd0);
        rd_step(tlb_pkg::reg_entrylo1, 32'd0);
        rd_step(tlb_pkg::reg_entryhi, 32'd0);
        add_row(op_if, 8'h00, 32'h0000_0abc, 1, ok);
        add_row(op_dm, 8'h00, 32'h0000_1ff0, 1, ok);
        // tlbwi into entry 3, clobber, then tlbr back
        a_lo0 = make_lo(3'd3, 1'b1, 1'b1, 1'b0);
        a_lo1 = make_lo(3'd2, 1'b0, 1'b1, 1'b1);
        wr_step(tlb_pkg::reg_entryhi, 32'h2468_a005);
        wr_step(tlb_pkg::reg_entrylo0, a_lo0);
        wr_step(tlb_pkg::reg_entrylo1, a_lo1);
        wr_step(tlb_pkg::reg_index, 32'd3);
        wr_step(tlb_pkg::reg_command, 32'(tlb_pkg::cmd_tlbwi));
        wr_step(tlb_pkg::reg_entryhi, 32'd0);
        wr_step(tlb_pkg::reg_entrylo0, 32'd0);
        wr_step(tlb_pkg::reg_entrylo1, 32'd0);
        wr_step(tlb_pkg::reg_command, 32'(tlb_pkg::cmd_tlbr));
        rd_step(tlb_pkg::reg_entryhi, 32'h2468_a005);
        rd_step(tlb_pkg::reg_entrylo0, a_lo0);
        rd_step(tlb_pkg::reg_entrylo1, a_lo1 & ~32'd1);  // g of entry is 0
        add_row(op_if, 8'h00, 32'h2468_a123, 1, ok);
        add_row(op_dm, 8'h00, 32'h2468_b456, 1, ok);
        add_row(op_if, 8'h00, 32'h2468_a010, 3, ok);     // third one leaves the pair
        add_row(op_dm, 8'h00, 32'h2468_a7fc, 2, ok);
        // global entry 5, then a foreign asid
        b_lo0 = make_lo(3'd5, 1'b1, 1'b1, 1'b1);
        b_lo1 = make_lo(3'd1, 1'b1, 1'b0, 1'b1);
        wr_step(tlb_pkg::reg_entryhi, 32'h1579_a007);
        wr_step(tlb_pkg::reg_entrylo0, b_lo0);
        wr_step(tlb_pkg::reg_entrylo1, b_lo1);
        wr_step(tlb_pkg::reg_index, 32'd5);
        wr_step(tlb_pkg::reg_command, 32'(tlb_pkg::cmd_tlbwi));
        wr_step(tlb_pkg::reg_entryhi, 32'h1579_a009);
        add_row(op_dm, 8'h00, 32'h1579_a020, 2, ok);
        add_row(op_if, 8'h00, 32'h2468_a020, 1, ok);
        // probes
        wr_step(tlb_pkg::reg_entryhi, 32'h2468_a005);
        wr_step(tlb_pkg::reg_command, 32'(tlb_pkg::cmd_tlbp));
        rd_step(tlb_pkg::reg_index, 32'd3);
        wr_step(tlb_pkg::reg_entryhi, 32'h1579_a042);
        wr_step(tlb_pkg::reg_command, 32'(tlb_pkg::cmd_tlbp));
        rd_step(tlb_pkg::reg_index, 32'd5);
        wr_step(tlb_pkg::reg_entryhi, 32'he000_2005);
        wr_step(tlb_pkg::reg_command, 32'(tlb_pkg::cmd_tlbp));
        rd_step(tlb_pkg::reg_index, 32'h8000_0000);
        // three tlbwr land in 15, 14, 13
        for (int i = 0; i < 3; i++) begin
            wr_step(tlb_pkg::reg_entryhi, 32'h0020_0005 + 32'(i) * 32'h2000);
            wr_step(tlb_pkg::reg_entrylo0, make_lo(3'(i), 1'b1, 1'b1, 1'b0));
            wr_step(tlb_pkg::reg_entrylo1, make_lo(3'd7, 1'b0, 1'b1, 1'b0));
            wr_step(tlb_pkg::reg_command, 32'(tlb_pkg::cmd_tlbwr));
        end
        for (int i = 0; i < 3; i++) begin
            add_row(op_dm, 8'h00, 32'h0020_0abc + 32'(i) * 32'h2000, 2, ok);
        end
        rd_step(tlb_pkg::reg_random, 32'd12);
        wr_step(tlb_pkg::reg_index, 32'd15);
        wr_step(tlb_pkg::reg_command, 32'(tlb_pkg::cmd_tlbr));
        rd_step(tlb_pkg::reg_entryhi, 32'h0020_0005);
        // error responses and stalled channels
        add_row(op_wr, tlb_pkg::reg_random, 32'd3, 5, err);
        add_row(op_wr, 8'h20, 32'hffff_ffff, 0, err);
        add_row(op_rd, tlb_pkg::reg_random, 32'd12, 0, ok);
        add_row(op_rd, tlb_pkg::reg_command, 32'd0, 4, err);
        add_row(op_rd, 8'h1c, 32'd0, 0, err);
        add_row(op_rd, tlb_pkg::reg_entryhi, 32'h0020_0005, 3, ok);
        wr_step(tlb_pkg::reg_command, 32'd7);   // unused code
        rd_step(tlb_pkg::reg_random, 32'd12);
    endtask

    task automatic axil_write(input row_t r);
        tlb_pkg::axil_resp_t got;
        awaddr  = r.addr;
        wdata   = r.data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge aclk);
        while (!(awready && wready)) @(negedge aclk);
        @(posedge aclk);
        #in_delay;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        model_write(r.addr, r.data);
        @(negedge aclk);
        while (!bvalid) @(negedge aclk);
        got = bresp;
        assert (got == r.resp)
            else note_mismatch($sformatf("write %h bresp %0d, expected %0d", r.addr, got, r.resp));
        assert (!awready && !wready)
            else note_mismatch("awready or wready still high while bvalid was up");
        repeat (r.stall) begin
            @(negedge aclk);
            assert (bvalid && bresp == got && !awready && !wready)
                else note_mismatch("b channel changed while bready was low");
        end
        @(posedge aclk);
        #in_delay;
        bready = 1'b1;
        @(posedge aclk);
        #in_delay;
        bready = 1'b0;
    endtask

    task automatic axil_read(input row_t r);
        tlb_pkg::axil_data_t got_data;
        tlb_pkg::axil_resp_t got_resp;
        araddr  = r.addr;
        arvalid = 1'b1;
        @(negedge aclk);
        while (!arready) @(negedge aclk);
        @(posedge aclk);
        #in_delay;
        arvalid = 1'b0;
        @(negedge aclk);
        while (!rvalid) @(negedge aclk);
        got_data = rdata;
        got_resp = rresp;
        assert (got_resp == r.resp && got_data == r.data)
            else note_mismatch($sformatf("read %h gave %h resp %0d, expected %h resp %0d",
                                         r.addr, got_data, got_resp, r.data, r.resp));
        assert (!arready)
            else note_mismatch("arready still high while rvalid was up");
        repeat (r.stall) begin
            @(negedge aclk);
            assert (rvalid && rdata == got_data && rresp == got_resp && !arready)
                else note_mismatch("r channel changed while rready was low");
        end
        @(posedge aclk);
        #in_delay;
        rready = 1'b1;
        @(posedge aclk);
        #in_delay;
        rready = 1'b0;
    endtask

    task automatic drive_req(input op_t op, input logic valid, input logic [31:0] va);
        if (op == op_if) begin
            if_req_valid = valid;
            if_vaddr     = va;
        end else begin
            dm_req_valid = valid;
            dm_vaddr     = va;
        end
    endtask

    task automatic check_rsp(input op_t op, input logic [31:0] va);
        logic        got_valid, got_hit, got_d, got_v;
        logic [31:0] got_pa, exp_pa, lo;
        logic [2:0]  got_c;
        int          e;
        {got_valid, got_hit, got_pa, got_c, got_d, got_v} = (op == op_if) ?
            {if_rsp_valid, if_hit, if_paddr, if_c, if_d, if_v} :
            {dm_rsp_valid, dm_hit, dm_paddr, dm_c, dm_d, dm_v};
        e = find_entry(va[31:13], m_hi[7:0]);
        lo = (e < 0) ? 32'd0 : (va[12] ? m_ent_lo1[e] : m_ent_lo0[e]);
        exp_pa = (e < 0) ? 32'd0 : {lo[25:6], va[11:0]};
        assert (got_valid && got_hit == (e >= 0) && got_pa == exp_pa &&
                got_c == lo[5:3] && got_d == lo[2] && got_v == lo[1])
            else note_mismatch($sformatf(
                "lookup %h: rv %b hit %b pa %h c %0d d %b v %b, exp hit %b pa %h c %0d d %b v %b",
                va, got_valid, got_hit, got_pa, got_c, got_d, got_v,
                e >= 0, exp_pa, lo[5:3], lo[2], lo[1]));
    endtask

    // one request per cycle, each answer checked a cycle later
    task automatic translate(input row_t r);
        int n;
        n = (r.stall < 1) ? 1 : r.stall;
        drive_req(r.op, 1'b1, r.data);
        for (int k = 1; k <= n; k++) begin
            @(posedge aclk);
            #in_delay;
            drive_req(r.op, k < n, r.data + 32'(k) * 32'h1000);
            @(negedge aclk);
            check_rsp(r.op, r.data + 32'(k - 1) * 32'h1000);
        end
    endtask

    initial begin
        rst_n        = 1'b0;
        awaddr       = '0;
        awvalid      = 1'b0;
        wdata        = '0;
        wstrb        = 4'hf;
        wvalid       = 1'b0;
        bready       = 1'b0;
        araddr       = '0;
        arvalid      = 1'b0;
        rready       = 1'b0;
        if_req_valid = 1'b0;
        if_vaddr     = '0;
        dm_req_valid = 1'b0;
        dm_vaddr     = '0;
        m_hi     = '0;
        m_lo0    = '0;
        m_lo1    = '0;
        m_index  = '0;
        m_random = 4'd15;
        for (int i = 0; i < 16; i++) begin
            store_entry(4'(i));     // model regs are zero here
        end
        build_table();
        n_rows = rows.size();
        repeat (2) @(posedge aclk);
        #in_delay;
        rst_n = 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            cur_row = i;
            row_bad = 1'b0;
            @(posedge aclk);
            #in_delay;
            case (rows[i].op)
                op_wr:   axil_write(rows[i]);
                op_rd:   axil_read(rows[i]);
                default: translate(rows[i]);
            endcase
            if (row_bad) begin
                n_fail++;
            end else begin
                n_pass++;
            end
            $display("row %0d %s addr %h data %h: %s", i, rows[i].op.name(), rows[i].addr,
                     rows[i].data, row_bad ? "failed" : "ok");
        end
        $display("%0d rows passed, %0d rows failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // watchdog, sized from the table length
    initial begin
        wait (n_rows > 0);
        #(clk_period * (n_rows * 20 + 50));
        $display("timeout: the rows did not finish within %0d clock periods", n_rows * 20 + 50);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
tlb_pkg.sv
tlb_entries.sv
tlb_lookup.sv
tlb_regs.sv
tlb_mmu_top.sv
tb_tlb_mmu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_tlb_mmu
RTL_TOP   ?= tlb_mmu_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= Result: PASSED

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
